// File: include/ecd_defs.svh
`ifndef ECD_DEFS_SVH
`define ECD_DEFS_SVH

// ==========================================================================
// Bus widths
// ==========================================================================

// Width of one AXI read beat and of one stream word
`define ECD_DATA_WIDTH 512

// Number of bytes carried by one beat
`define ECD_DATA_BYTES (`ECD_DATA_WIDTH / 8)

// AXI address width, wide enough for a host buffer anywhere in memory
`define ECD_ADDR_WIDTH 64

// Host register data width
`define ECD_REG_WIDTH 32

// ==========================================================================
// Burst geometry and register decode
// ==========================================================================

// Every read request fetches this many beats
`define ECD_BEATS_PER_BURST 32

// Address step from one burst to the next
`define ECD_BYTES_PER_BURST (`ECD_DATA_BYTES * `ECD_BEATS_PER_BURST)

// The register bank owns 128 bytes of address space (32 words)
`define ECD_ADDR_MASK 7'h7F

`endif

// File: rtl/ecd_pkg.sv
package ecd_pkg;

    // ======================================================================
    // Register map
    // ======================================================================

    // Word indices of the host registers, after masking and the shift by two
    typedef enum logic [4:0] {
        REG_BUFFH     = 5'd0,   // Upper 32 bits of the buffer base address
        REG_BUFFL     = 5'd1,   // Lower 32 bits of the buffer base address
        REG_BUFF_SIZE = 5'd2,   // Buffer size, counted in bursts
        REG_START     = 5'd3,   // Write-only, any write starts fetching
        REG_PAUSE     = 5'd4    // Non-zero holds off new read requests
    } reg_index_e;

    // Response codes returned for host register accesses
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } resp_e;

    // ======================================================================
    // Read request FSM
    // ======================================================================

    // FETCH_IDLE is left on the first start and never entered again
    typedef enum logic [1:0] {
        FETCH_IDLE        = 2'd0,
        FETCH_ISSUE       = 2'd1,
        FETCH_WAIT_ACCEPT = 2'd2,
        FETCH_PAUSED      = 2'd3
    } fetch_state_e;

endpackage

// File: rtl/ecd_ctrl_regs.sv
`timescale 1ns/1ps

`include "ecd_defs.svh"

module ecd_ctrl_regs (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       reg_write,
    input  logic [`ECD_REG_WIDTH-1:0]  reg_waddr,
    input  logic [`ECD_REG_WIDTH-1:0]  reg_wdata,
    input  logic                       reg_read,
    input  logic [`ECD_REG_WIDTH-1:0]  reg_raddr,
    output ecd_pkg::resp_e             reg_wresp,
    output logic [`ECD_REG_WIDTH-1:0]  reg_rdata,
    output ecd_pkg::resp_e             reg_rresp,
    output logic [`ECD_ADDR_WIDTH-1:0] buff_base,
    output logic [`ECD_REG_WIDTH-1:0]  buff_size,
    output logic                       start,
    output logic                       pause_dma
);

    // Storage for the four writable registers
    logic [`ECD_REG_WIDTH-1:0] buffh_q;
    logic [`ECD_REG_WIDTH-1:0] buffl_q;
    logic [`ECD_REG_WIDTH-1:0] size_q;
    logic [`ECD_REG_WIDTH-1:0] pause_q;

    // Host byte addresses after masking to the 128-byte window
    logic [`ECD_REG_WIDTH-1:0] waddr_masked;
    logic [`ECD_REG_WIDTH-1:0] raddr_masked;
    logic [4:0]                widx;
    logic [4:0]                ridx;

    // Read decode result, registered when reg_read is seen
    logic                      rd_hit;
    logic [`ECD_REG_WIDTH-1:0] rd_value;

    assign waddr_masked = reg_waddr & `ECD_REG_WIDTH'(`ECD_ADDR_MASK);
    assign raddr_masked = reg_raddr & `ECD_REG_WIDTH'(`ECD_ADDR_MASK);

    // Byte address to word index
    assign widx = 5'(waddr_masked >> 2);
    assign ridx = 5'(raddr_masked >> 2);

    // The base address is presented as one 64-bit value
    assign buff_base = {buffh_q, buffl_q};
    assign buff_size = size_q;

    // Fetching is held off for as long as the countdown has not reached zero
    assign pause_dma = (pause_q != '0);

    // ======================================================================
    // Write decode, pause countdown and start pulse
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            buffh_q   <= '0;
            buffl_q   <= '0;
            size_q    <= '0;
            pause_q   <= '0;
            start     <= 1'b0;
            reg_wresp <= ecd_pkg::RESP_OKAY;
        end else begin
            // Start only ever lasts one cycle
            start <= 1'b0;

            // The pause register runs down by one per cycle toward zero
            if (pause_q != '0) begin
                pause_q <= pause_q - 1'b1;
            end

            // A host write overrides the countdown in the same cycle
            if (reg_write) begin
                reg_wresp <= ecd_pkg::RESP_OKAY;
                case (widx)
                    ecd_pkg::REG_BUFFH:     buffh_q <= reg_wdata;
                    ecd_pkg::REG_BUFFL:     buffl_q <= reg_wdata;
                    ecd_pkg::REG_BUFF_SIZE: size_q  <= reg_wdata;
                    ecd_pkg::REG_PAUSE:     pause_q <= reg_wdata;
                    // Nothing is stored, the write only kicks off fetching
                    ecd_pkg::REG_START:     start   <= 1'b1;
                    default:                reg_wresp <= ecd_pkg::RESP_DECERR;
                endcase
            end
        end
    end

    // ======================================================================
    // Read decode
    // ======================================================================

    // START is write-only, so it decodes like an unmapped word on reads
    always_comb begin
        rd_hit   = 1'b1;
        rd_value = '0;
        case (ridx)
            ecd_pkg::REG_BUFFH:     rd_value = buffh_q;
            ecd_pkg::REG_BUFFL:     rd_value = buffl_q;
            ecd_pkg::REG_BUFF_SIZE: rd_value = size_q;
            ecd_pkg::REG_PAUSE:     rd_value = pause_q;
            default:                rd_hit   = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            reg_rresp <= ecd_pkg::RESP_OKAY;
        end else if (reg_read) begin
            reg_rresp <= rd_hit ? ecd_pkg::RESP_OKAY : ecd_pkg::RESP_DECERR;
        end
    end

    // Read data is a plain capture register
    always_ff @(posedge clk) begin
        if (reg_read) begin
            reg_rdata <= rd_value;
        end
    end

    // The requester and the block counter both expect a single-cycle start
    assert property (@(posedge clk) disable iff (!resetn) start |=> !start)
        else $error("start held high for more than one cycle");

endmodule

// File: rtl/ecd_ar_requester.sv
`timescale 1ns/1ps

`include "ecd_defs.svh"

module ecd_ar_requester (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       start,
    input  logic                       pause_dma,
    input  logic [`ECD_ADDR_WIDTH-1:0] buff_base,
    input  logic [`ECD_REG_WIDTH-1:0]  buff_size,
    input  logic                       ar_ready,
    output logic [`ECD_ADDR_WIDTH-1:0] ar_addr,
    output logic                       ar_valid,
    output logic                       fetch_idle
);

    ecd_pkg::fetch_state_e state;

    // Requests still to be issued in the current pass, this one included
    logic [`ECD_REG_WIDTH-1:0] blocks_left;

    // First request of a pass, taken from the base address
    logic load_first;

    // Move on to the next burst of the same pass
    logic advance;

    // The current request is the last block of the buffer
    logic last_block;

    assign fetch_idle = (state == ecd_pkg::FETCH_IDLE);
    assign last_block = (blocks_left == `ECD_REG_WIDTH'(1));

    assign load_first = (state == ecd_pkg::FETCH_ISSUE) && !pause_dma;

    // Either straight after an acceptance or on leaving the paused state
    assign advance = ((state == ecd_pkg::FETCH_WAIT_ACCEPT) && ar_ready && !last_block &&
                      !pause_dma) ||
                     ((state == ecd_pkg::FETCH_PAUSED) && !pause_dma);

    // ======================================================================
    // State and AR valid
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= ecd_pkg::FETCH_IDLE;
            ar_valid <= 1'b0;
        end else begin
            case (state)
                // Waits here for the very first start after reset
                ecd_pkg::FETCH_IDLE: begin
                    if (start) begin
                        state <= ecd_pkg::FETCH_ISSUE;
                    end
                end
                ecd_pkg::FETCH_ISSUE: begin
                    if (load_first) begin
                        ar_valid <= 1'b1;
                        state    <= ecd_pkg::FETCH_WAIT_ACCEPT;
                    end
                end
                ecd_pkg::FETCH_WAIT_ACCEPT: begin
                    if (ar_ready) begin
                        if (last_block) begin
                            // Wrap around and restart from the base
                            ar_valid <= 1'b0;
                            state    <= ecd_pkg::FETCH_ISSUE;
                        end else if (pause_dma) begin
                            ar_valid <= 1'b0;
                            state    <= ecd_pkg::FETCH_PAUSED;
                        end
                    end
                end
                ecd_pkg::FETCH_PAUSED: begin
                    if (advance) begin
                        ar_valid <= 1'b1;
                        state    <= ecd_pkg::FETCH_WAIT_ACCEPT;
                    end
                end
                default: begin
                    ar_valid <= 1'b0;
                    state    <= ecd_pkg::FETCH_IDLE;
                end
            endcase
        end
    end

    // ======================================================================
    // Address and block count
    // ======================================================================

    // Both change only as a request is presented, so they stay put while it waits
    always_ff @(posedge clk) begin
        if (load_first) begin
            ar_addr     <= buff_base;
            blocks_left <= buff_size;
        end else if (advance) begin
            ar_addr     <= ar_addr + `ECD_ADDR_WIDTH'(`ECD_BYTES_PER_BURST);
            blocks_left <= blocks_left - 1'b1;
        end
    end

    // A raised AR request holds still until the slave takes it
    assert property (@(posedge clk) disable iff (!resetn)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
        else $error("AR request changed before it was accepted");

endmodule

// File: rtl/ecd_read_data_path.sv
`timescale 1ns/1ps

`include "ecd_defs.svh"

module ecd_read_data_path (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       fetch_idle,
    input  logic                       start,
    input  logic [`ECD_REG_WIDTH-1:0]  buff_size,
    input  logic [`ECD_DATA_WIDTH-1:0] rd_data,
    input  logic                       rd_valid,
    input  logic                       rd_last,
    input  logic                       stream_ready,
    output logic                       rd_ready,
    output logic [`ECD_DATA_WIDTH-1:0] stream_data,
    output logic                       stream_valid,
    output logic                       draining,
    output logic                       irq_eob
);

    // Blocks still to arrive before the buffer has been read through
    logic [`ECD_REG_WIDTH-1:0] blocks_to_read;

    // Final beat of a block accepted while fetching
    logic block_done;

    // ======================================================================
    // R channel to stream
    // ======================================================================

    // The host bridge hands over little-endian words, so the byte order is
    // flipped to restore the original layout
    always_comb begin
        for (int i = 0; i < `ECD_DATA_BYTES; i++) begin
            stream_data[i*8 +: 8] = rd_data[(`ECD_DATA_BYTES-1-i)*8 +: 8];
        end
    end

    // Nothing is forwarded before the first start
    assign stream_valid = rd_valid && !fetch_idle;

    // Stream back-pressure stalls the R channel, except before start where
    // every beat is swallowed
    assign rd_ready = stream_ready || fetch_idle;

    // Debug level that marks beats thrown away before the first start
    assign draining = fetch_idle && rd_valid && rd_ready;

    assign block_done = !fetch_idle && rd_valid && rd_ready && rd_last;

    // ======================================================================
    // End-of-buffer interrupt
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            blocks_to_read <= '0;
            irq_eob        <= 1'b0;
        end else begin
            // One-cycle pulse unless set again below
            irq_eob <= 1'b0;

            if (start) begin
                blocks_to_read <= buff_size;
            end else if (block_done) begin
                if (blocks_to_read == `ECD_REG_WIDTH'(1)) begin
                    // Last block of the buffer has landed, go round again
                    blocks_to_read <= buff_size;
                    irq_eob        <= 1'b1;
                end else begin
                    blocks_to_read <= blocks_to_read - 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!resetn) irq_eob |=> !irq_eob)
        else $error("irq_eob held high for more than one cycle");

endmodule

// File: rtl/ecd_master_ctrl.sv
`timescale 1ns/1ps

`include "ecd_defs.svh"

module ecd_master_ctrl (
    input  logic                       clk,
    input  logic                       resetn,

    // Host register access, strobe based
    input  logic                       reg_write,
    input  logic [`ECD_REG_WIDTH-1:0]  reg_waddr,
    input  logic [`ECD_REG_WIDTH-1:0]  reg_wdata,
    output ecd_pkg::resp_e             reg_wresp,
    input  logic                       reg_read,
    input  logic [`ECD_REG_WIDTH-1:0]  reg_raddr,
    output logic [`ECD_REG_WIDTH-1:0]  reg_rdata,
    output ecd_pkg::resp_e             reg_rresp,

    // AXI read address channel
    output logic [`ECD_ADDR_WIDTH-1:0] ar_addr,
    output logic                       ar_valid,
    input  logic                       ar_ready,
    output logic [7:0]                 ar_len,
    output logic [2:0]                 ar_size,
    output logic [1:0]                 ar_burst,

    // AXI read data channel
    input  logic [`ECD_DATA_WIDTH-1:0] rd_data,
    input  logic                       rd_valid,
    input  logic                       rd_last,
    output logic                       rd_ready,

    // AXI-Stream output
    output logic [`ECD_DATA_WIDTH-1:0] stream_data,
    output logic                       stream_valid,
    input  logic                       stream_ready,

    // Debug level and end-of-buffer interrupt
    output logic                       draining,
    output logic                       irq_eob
);

    logic                       start;
    logic                       pause_dma;
    logic                       fetch_idle;
    logic [`ECD_ADDR_WIDTH-1:0] buff_base;
    logic [`ECD_REG_WIDTH-1:0]  buff_size;

    // ======================================================================
    // Fixed burst fields
    // ======================================================================

    // AXI encodes the length as beats minus one
    assign ar_len   = 8'(`ECD_BEATS_PER_BURST - 1);
    // Full-width beats, log2 of the bytes per beat
    assign ar_size  = 3'($clog2(`ECD_DATA_BYTES));
    // INCR
    assign ar_burst = 2'b01;

    // ======================================================================
    // Submodules
    // ======================================================================
    ecd_ctrl_regs u_ctrl_regs (
        .clk       (clk),
        .resetn    (resetn),
        .reg_write (reg_write),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_read  (reg_read),
        .reg_raddr (reg_raddr),
        .reg_wresp (reg_wresp),
        .reg_rdata (reg_rdata),
        .reg_rresp (reg_rresp),
        .buff_base (buff_base),
        .buff_size (buff_size),
        .start     (start),
        .pause_dma (pause_dma)
    );

    ecd_ar_requester u_ar_requester (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .pause_dma  (pause_dma),
        .buff_base  (buff_base),
        .buff_size  (buff_size),
        .ar_ready   (ar_ready),
        .ar_addr    (ar_addr),
        .ar_valid   (ar_valid),
        .fetch_idle (fetch_idle)
    );

    ecd_read_data_path u_read_data_path (
        .clk          (clk),
        .resetn       (resetn),
        .fetch_idle   (fetch_idle),
        .start        (start),
        .buff_size    (buff_size),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .rd_last      (rd_last),
        .stream_ready (stream_ready),
        .rd_ready     (rd_ready),
        .stream_data  (stream_data),
        .stream_valid (stream_valid),
        .draining     (draining),
        .irq_eob      (irq_eob)
    );

endmodule

// File: verif/tb_ecd_master_ctrl.sv
`timescale 1ns/1ps

`include "ecd_defs.svh"

module tb_ecd_master_ctrl;

    localparam logic [63:0] BUF_BASE       = 64'h0000_0042_8000_0000;
    localparam int unsigned BUF_SIZE       = 3;
    localparam int unsigned PAUSE_COUNT    = 40;
    localparam int unsigned BEATS          = 32;
    // About 9 bursts of 32 beats at under two cycles per beat, plus the register
    // phase, need well under a thousand cycles, so this leaves a wide margin
    localparam int unsigned TIMEOUT_CYCLES = 20000;

    // DUT inputs, all with a defined value from time zero
    logic                       clk          = 1'b0;
    logic                       resetn       = 1'b0;
    logic                       reg_write    = 1'b0;
    logic [`ECD_REG_WIDTH-1:0]  reg_waddr    = '0;
    logic [`ECD_REG_WIDTH-1:0]  reg_wdata    = '0;
    logic                       reg_read     = 1'b0;
    logic [`ECD_REG_WIDTH-1:0]  reg_raddr    = '0;
    logic                       ar_ready     = 1'b0;
    logic [`ECD_DATA_WIDTH-1:0] rd_data      = '0;
    logic                       rd_valid     = 1'b0;
    logic                       rd_last      = 1'b0;
    logic                       stream_ready = 1'b0;

    // DUT outputs
    ecd_pkg::resp_e             reg_wresp;
    ecd_pkg::resp_e             reg_rresp;
    logic [`ECD_REG_WIDTH-1:0]  reg_rdata;
    logic [`ECD_ADDR_WIDTH-1:0] ar_addr;
    logic                       ar_valid;
    logic [7:0]                 ar_len;
    logic [2:0]                 ar_size;
    logic [1:0]                 ar_burst;
    logic                       rd_ready;
    logic [`ECD_DATA_WIDTH-1:0] stream_data;
    logic                       stream_valid;
    logic                       draining;
    logic                       irq_eob;

    // Expected host responses, held from the strobe until the next access
    ecd_pkg::resp_e            exp_wresp = ecd_pkg::RESP_OKAY;
    ecd_pkg::resp_e            exp_rresp = ecd_pkg::RESP_OKAY;
    logic [`ECD_REG_WIDTH-1:0] exp_rdata = '0;

    // Phase flags, fetching mirrors the requester leaving idle
    logic pre_start = 1'b1;
    logic fetching  = 1'b0;

    // Reference counters built from the bus traffic
    int unsigned               ar_count    = 0;
    int unsigned               last_cnt    = 0;
    int unsigned               cycle_cnt   = 0;
    logic [`ECD_REG_WIDTH-1:0] pause_model = '0;

    // Memory slave state
    logic [63:0] ar_queue[$];
    logic [63:0] burst_addr = '0;
    logic        burst_open = 1'b0;
    int unsigned beat_num   = 0;

    ecd_master_ctrl UUT (.*);

    always #50 clk = ~clk;

    // ======================================================================
    // Helpers
    // ======================================================================

    // Byte i of the result is byte 63-i of the input
    function automatic logic [`ECD_DATA_WIDTH-1:0] reverse_bytes(
        input logic [`ECD_DATA_WIDTH-1:0] d);
        reverse_bytes = {<<8{d}};
    endfunction

    // The burst address and beat number sit in the top bits over a random fill
    function automatic logic [`ECD_DATA_WIDTH-1:0] make_beat(input logic [63:0] addr,
                                                             input int unsigned beat);
        logic [`ECD_DATA_WIDTH-1:0] d;
        for (int w = 0; w < `ECD_DATA_WIDTH / 32; w++) begin
            d[w*32 +: 32] = $urandom;
        end
        d[`ECD_DATA_WIDTH-1 -: 64] = addr;
        d[`ECD_DATA_WIDTH-65 -: 32] = 32'(beat);
        return d;
    endfunction

    function automatic logic [31:0] reg_addr(input ecd_pkg::reg_index_e idx);
        return {25'd0, idx, 2'b00};
    endfunction

    task automatic report_error(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                             input ecd_pkg::resp_e resp);
        @(posedge clk);
        reg_write <= 1'b1;
        reg_waddr <= addr;
        reg_wdata <= data;
        exp_wresp <= resp;
        @(posedge clk);
        reg_write <= 1'b0;
    endtask

    task automatic read_reg(input logic [31:0] addr, input logic [31:0] data,
                            input ecd_pkg::resp_e resp);
        @(posedge clk);
        reg_read  <= 1'b1;
        reg_raddr <= addr;
        exp_rdata <= data;
        exp_rresp <= resp;
        @(posedge clk);
        reg_read <= 1'b0;
    endtask

    // ======================================================================
    // Random ready gaps, reference counters and timeout
    // ======================================================================
    always @(posedge clk) begin
        ar_ready     <= ($urandom % 3) != 0;
        stream_ready <= ($urandom % 4) != 0;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (!resetn) begin
            ar_count    <= 0;
            last_cnt    <= 0;
            pause_model <= '0;
        end else begin
            if (ar_valid && ar_ready) begin
                ar_count <= ar_count + 1;
            end
            if (fetching && rd_valid && rd_ready && rd_last) begin
                last_cnt <= last_cnt + 1;
            end
            // A write to word 4 reloads the countdown, otherwise it runs down
            if (reg_write && ((reg_waddr & 32'h7F) >> 2) == 32'd4) begin
                pause_model <= reg_wdata;
            end else if (pause_model != '0) begin
                pause_model <= pause_model - 1;
            end
        end
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: the test did not finish within %0d clock cycles",
                     TIMEOUT_CYCLES);
            $display("Done: errors found");
            $fatal(1);
        end
    end

    // ======================================================================
    // Memory slave, one 32-beat burst per accepted AR request
    // ======================================================================
    always @(posedge clk) begin
        if (!resetn) begin
            rd_valid   <= 1'b0;
            rd_last    <= 1'b0;
            burst_open = 1'b0;
            beat_num   = 0;
            ar_queue.delete();
        end else begin
            if (ar_valid && ar_ready) begin
                ar_queue.push_back(ar_addr);
            end
            // Retire the beat that was just taken
            if (rd_valid && rd_ready && burst_open) begin
                beat_num = beat_num + 1;
                if (beat_num == BEATS) begin
                    burst_open = 1'b0;
                end
            end
            if (!burst_open && ar_queue.size() > 0) begin
                burst_addr = ar_queue.pop_front();
                burst_open = 1'b1;
                beat_num   = 0;
            end
            // A beat that is still waiting for rd_ready stays as it is
            if (!rd_valid || rd_ready) begin
                if (pre_start) begin
                    // Stray traffic before the first start, to be discarded
                    rd_valid <= ($urandom % 2) == 0;
                    rd_last  <= ($urandom % 8) == 0;
                    rd_data  <= make_beat('0, $urandom % BEATS);
                end else if (burst_open) begin
                    rd_valid <= ($urandom % 4) != 0;
                    rd_last  <= (beat_num == BEATS - 1);
                    rd_data  <= make_beat(burst_addr, beat_num);
                end else begin
                    rd_valid <= 1'b0;
                    rd_last  <= 1'b0;
                end
            end
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================
    assert property (@(posedge clk) disable iff (!resetn) reg_write |=> reg_wresp == exp_wresp)
        else report_error("wrong register write response");

    assert property (@(posedge clk) disable iff (!resetn)
        reg_read |=> reg_rresp == exp_rresp &&
                     (exp_rresp != ecd_pkg::RESP_OKAY || reg_rdata == exp_rdata))
        else report_error("wrong register read data or response");

    // With three blocks the addresses run base, +2048, +4096 and wrap
    assert property (@(posedge clk) disable iff (!resetn)
        ar_valid && ar_ready |-> ar_addr == BUF_BASE + 64'(ar_count % BUF_SIZE) * 64'd2048)
        else report_error("accepted AR address out of sequence");

    assert property (@(posedge clk) disable iff (!resetn)
        ar_valid |-> ar_len == 8'd31 && ar_size == 3'd6 && ar_burst == 2'b01)
        else report_error("wrong burst fields on the AR channel");

    assert property (@(posedge clk) disable iff (!resetn)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
        else report_error("AR request changed before acceptance");

    // No new request may be raised while the pause count is non-zero
    assert property (@(posedge clk) disable iff (!resetn)
        pause_model != '0 && !ar_valid |=> !ar_valid)
        else report_error("AR request raised during pause");

    assert property (@(posedge clk) disable iff (!resetn)
        !fetching |-> !ar_valid && !irq_eob)
        else report_error("activity before the first start");

    assert property (@(posedge clk) disable iff (!resetn)
        rd_valid && !fetching |-> draining && rd_ready && !stream_valid)
        else report_error("idle beat was not drained");

    assert property (@(posedge clk) disable iff (!resetn)
        rd_valid && fetching |->
            stream_valid && !draining && stream_data == reverse_bytes(rd_data))
        else report_error("stream beat does not match the read beat");

    assert property (@(posedge clk) disable iff (!resetn) !rd_valid |-> !stream_valid)
        else report_error("stream_valid without rd_valid");

    assert property (@(posedge clk) disable iff (!resetn) fetching |-> rd_ready == stream_ready)
        else report_error("rd_ready differs from stream_ready while fetching");

    // Every third block end while fetching closes the buffer
    assert property (@(posedge clk) disable iff (!resetn)
        fetching && rd_valid && rd_ready && rd_last |=> irq_eob == (last_cnt % BUF_SIZE == 0))
        else report_error("irq_eob wrong after a block end");

    assert property (@(posedge clk) disable iff (!resetn)
        !(fetching && rd_valid && rd_ready && rd_last) |=> !irq_eob)
        else report_error("irq_eob without a block end");

    assert property (@(posedge clk) disable iff (!resetn) irq_eob |=> !irq_eob)
        else report_error("irq_eob high for two cycles");

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        void'($urandom(32'h08d6_d740));
        repeat (3) @(posedge clk);
        resetn <= 1'b1;

        // Register bank, while stray read beats are being drained
        write_reg(reg_addr(ecd_pkg::REG_BUFFH), BUF_BASE[63:32], ecd_pkg::RESP_OKAY);
        write_reg(reg_addr(ecd_pkg::REG_BUFFL), BUF_BASE[31:0], ecd_pkg::RESP_OKAY);
        // Address bit 7 is masked off, so this lands on BUFF_SIZE
        write_reg(32'h0000_0088, 32'(BUF_SIZE), ecd_pkg::RESP_OKAY);
        write_reg(32'h0000_0014, 32'h1234_5678, ecd_pkg::RESP_DECERR);
        write_reg(32'h0000_007C, 32'h0BAD_F00D, ecd_pkg::RESP_DECERR);
        read_reg(reg_addr(ecd_pkg::REG_BUFFH), BUF_BASE[63:32], ecd_pkg::RESP_OKAY);
        read_reg(reg_addr(ecd_pkg::REG_BUFFL), BUF_BASE[31:0], ecd_pkg::RESP_OKAY);
        read_reg(reg_addr(ecd_pkg::REG_BUFF_SIZE), 32'(BUF_SIZE), ecd_pkg::RESP_OKAY);
        read_reg(reg_addr(ecd_pkg::REG_START), '0, ecd_pkg::RESP_DECERR);
        read_reg(32'h0000_0014, '0, ecd_pkg::RESP_DECERR);
        read_reg(32'h0000_0060, '0, ecd_pkg::RESP_DECERR);

        repeat (10) @(posedge clk);
        pre_start <= 1'b0;
        repeat (3) @(posedge clk);
        write_reg(reg_addr(ecd_pkg::REG_START), 32'd1, ecd_pkg::RESP_OKAY);
        // Start pulses one edge after the strobe, the FSM leaves idle one later
        @(posedge clk);
        fetching <= 1'b1;

        // Let the walk wrap back to the base once
        while (ar_count < BUF_SIZE + 1) begin
            @(posedge clk);
        end

        // The count is N at the write edge and one lower at every edge after
        write_reg(reg_addr(ecd_pkg::REG_PAUSE), PAUSE_COUNT, ecd_pkg::RESP_OKAY);
        read_reg(reg_addr(ecd_pkg::REG_PAUSE), PAUSE_COUNT - 1, ecd_pkg::RESP_OKAY);
        read_reg(reg_addr(ecd_pkg::REG_PAUSE), PAUSE_COUNT - 3, ecd_pkg::RESP_OKAY);

        // Three full passes over the buffer, so three interrupts
        while (last_cnt < 3 * BUF_SIZE) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: ecd_master_ctrl.f
+incdir+include
rtl/ecd_pkg.sv
rtl/ecd_ctrl_regs.sv
rtl/ecd_ar_requester.sv
rtl/ecd_read_data_path.sv
rtl/ecd_master_ctrl.sv
verif/tb_ecd_master_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ecd_master_ctrl \
    -f ecd_master_ctrl.f

# A failing run exits non-zero, the log decides the verdict below
./obj_dir/Vtb_ecd_master_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation FAILED, see sim.log"
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "Simulation ended without a verdict, see sim.log"
    exit 1
fi
echo "Simulation passed"
